//--- design/arb_grant_select.sv
// Grant selection for the block arbiter

`default_nettype none

module arb_grant_select (
    input  wire arb_pkg::row_info_t              info,
    input  wire logic [arb_pkg::mac_num-1:0]     mac_req_help,
    input  wire logic [arb_pkg::psum_num-1:0]    psum_empty,
    input  wire logic [arb_pkg::psum_num-1:0]    psum_fnh,
    output arb_pkg::grant_t                      grant
);

    logic                               wei_found;
    logic [arb_pkg::mac_id_w-1:0]       wei_sel;
    logic [arb_pkg::psum_id_w-1:0]      psum_sel;
    logic                               mac_found;
    logic [arb_pkg::mac_id_w-1:0]       mac_sel;
    logic [arb_pkg::mac_num-1:0]        mac_one;

    // ==================================================================
    // Priority picks, lowest index first
    // ==================================================================
    always_comb begin
        wei_found = 1'b0;
        wei_sel   = '0;
        psum_sel  = '0;
        for (int w = 0; w < arb_pkg::mac_num; w++) begin
            // Psum still filling or free to start
            if (!wei_found && info.pending[w] &&
                (!psum_fnh[info.map[w]] || psum_empty[info.map[w]])) begin
                wei_found = 1'b1;
                wei_sel   = w[arb_pkg::mac_id_w-1:0];
                psum_sel  = info.map[w];
            end
        end

        mac_found = 1'b0;
        mac_sel   = '0;
        mac_one   = '0;
        for (int m = 0; m < arb_pkg::mac_num; m++) begin
            if (!mac_found && mac_req_help[m]) begin
                mac_found  = 1'b1;
                mac_sel    = m[arb_pkg::mac_id_w-1:0];
                mac_one[m] = 1'b1;
            end
        end

        grant.valid      = info.arb_active && wei_found && mac_found;
        grant.mac_id     = mac_sel;
        grant.mac_onehot = grant.valid ? mac_one : '0;
        grant.wei_id     = wei_sel;
        grant.psum_id    = psum_sel;
        grant.row        = info.row;

        // One MAC per grant and it matches the id
        if (grant.valid) begin
            a_onehot: assert ($onehot(grant.mac_onehot) && grant.mac_onehot[grant.mac_id])
                else $error("Grant one-hot does not match MAC id");
        end
    end

endmodule

`default_nettype wire

//--- design/arb_mac_dispatch.sv
// MAC dispatch registers

`default_nettype none

module arb_mac_dispatch (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire logic                                           sta,
    input  wire arb_pkg::grant_t                                grant,
    input  wire logic [arb_pkg::mac_num-1:0]                    mac_req_help,
    output logic [arb_pkg::mac_num-1:0]                         mac_rst,
    output arb_pkg::mac_assign_t [arb_pkg::mac_num-1:0]         mac_assign,
    output logic [arb_pkg::mac_num-1:0]                         mac_switch
);

    logic [arb_pkg::mac_num-1:0] new_bit;

    assign new_bit = grant.valid ? grant.mac_onehot : '0;

    // ==================================================================
    // Reset pulse to the granted MAC
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_rst <= '0;
        end else begin
            mac_rst <= new_bit;                    // Single cycle
        end
    end

    // Assignment entries
    always_ff @(posedge clk) begin
        if (sta) begin
            for (int m = 0; m < arb_pkg::mac_num; m++) begin
                mac_assign[m] <= '0;
            end
        end else if (grant.valid) begin
            mac_assign[grant.mac_id].row  <= grant.row;
            mac_assign[grant.mac_id].wei  <= grant.wei_id;
            mac_assign[grant.mac_id].psum <= grant.psum_id;
        end
    end

    // ==================================================================
    // Switch tracking
    // ==================================================================
    // A bit stays up while its MAC works and drops once it asks for help
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_switch <= '0;
        end else if (sta) begin
            mac_switch <= '0;
        end else begin
            mac_switch <= (mac_switch & ~mac_req_help) | new_bit;
        end
    end

    // Only an idle MAC may be handed a job
    a_rst_req: assert property (@(posedge clk) disable iff (!rst_n)
        (mac_rst & ~$past(mac_req_help)) == '0)
        else $error("MAC reset without prior help request");

endmodule

`default_nettype wire

//--- design/arb_pkg.sv
// Block arbiter shared types
// Sizes, structs and base psum map

`default_nettype none

package arb_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================
    localparam int mac_num   = 27;       // MAC units, also weights per row
    localparam int mac_id_w  = 5;
    localparam int psum_num  = 9;
    localparam int psum_id_w = 4;
    localparam int psum_fill = 9;        // Grants per psum
    localparam int row_w     = 8;        // Carried row field
    localparam int chan_num  = 3;
    localparam int chan_wei  = 9;        // Weights per channel

    typedef logic [mac_num-1:0][psum_id_w-1:0] psum_map_t;

    // ==================================================================
    // Stage structs
    // ==================================================================
    typedef struct packed {
        logic                  arb_active;
        logic [row_w-1:0]      row;
        logic [mac_num-1:0]    pending;  // Weights still to compute
        psum_map_t             map;
    } row_info_t;

    typedef struct packed {
        logic                  valid;
        logic [mac_id_w-1:0]   mac_id;
        logic [mac_num-1:0]    mac_onehot;
        logic [mac_id_w-1:0]   wei_id;
        logic [psum_id_w-1:0]  psum_id;
        logic [row_w-1:0]      row;
    } grant_t;

    typedef struct packed {
        logic [row_w-1:0]      row;
        logic [mac_id_w-1:0]   wei;
        logic [psum_id_w-1:0]  psum;
    } mac_assign_t;

    // Weights 0-2 to psum 3g, 3-5 to 3g+2, 6-8 to 3g+1
    function automatic psum_map_t make_base_map();
        psum_map_t m;
        for (int g = 0; g < chan_num; g++) begin
            for (int k = 0; k < 3; k++) begin
                m[g*chan_wei + k]     = psum_id_w'(3*g);
                m[g*chan_wei + 3 + k] = psum_id_w'(3*g + 2);
                m[g*chan_wei + 6 + k] = psum_id_w'(3*g + 1);
            end
        end
        return m;
    endfunction

    localparam psum_map_t base_psum_map = make_base_map();

endpackage

`default_nettype wire

//--- design/arb_psum_tracker.sv
// Psum fill counters and finish flags

`default_nettype none

module arb_psum_tracker (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            sta,
    input  wire arb_pkg::grant_t                 grant,
    input  wire logic [arb_pkg::psum_num-1:0]    psum_empty,
    output logic [arb_pkg::psum_num-1:0]         psum_fnh
);

    localparam int cnt_w = $clog2(arb_pkg::psum_fill);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(arb_pkg::psum_fill - 1);

    logic [cnt_w-1:0] cnt_q [arb_pkg::psum_num];

    // ==================================================================
    // One counter and flag per psum
    // ==================================================================
    for (genvar p = 0; p < arb_pkg::psum_num; p++) begin : g_psum
        logic hit;

        assign hit = grant.valid && (grant.psum_id == p);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt_q[p] <= '0;
            end else if (sta) begin
                cnt_q[p] <= '0;
            end else if (psum_fnh[p] && !psum_empty[p]) begin
                cnt_q[p] <= '0;                    // Psum busy draining
            end else if (hit) begin
                cnt_q[p] <= (cnt_q[p] == last_cnt) ? '0 : cnt_q[p] + 1'b1;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                psum_fnh[p] <= 1'b1;
            end else if (sta) begin
                psum_fnh[p] <= 1'b1;
            end else if (hit && psum_empty[p]) begin
                psum_fnh[p] <= 1'b0;               // First MAC into idle psum
            end else if (hit && cnt_q[p] == last_cnt) begin
                psum_fnh[p] <= 1'b1;               // Ninth MAC
            end
        end

        a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
            cnt_q[p] <= last_cnt)
            else $error("Psum fill counter overflow");
    end

endmodule

`default_nettype wire

//--- design/arb_row_tracker.sv
// Row tracker for the block arbiter

`default_nettype none

module arb_row_tracker #(
    parameter int ROW_NUM = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          sta,
    input  wire logic [arb_pkg::row_w-1:0]     row_cnt,    // Rows with flags counted
    input  wire arb_pkg::grant_t               grant,
    input  wire logic [arb_pkg::mac_num-1:0]   mac_switch,
    output arb_pkg::row_info_t                 info,
    output logic                               blk_fnh,
    output logic                               row_on,
    output logic [arb_pkg::row_w-1:0]          row_arb
);

    localparam int row_idx_w = $clog2(ROW_NUM);
    localparam logic [arb_pkg::row_w-1:0] last_row = arb_pkg::row_w'(ROW_NUM - 1);

    typedef enum logic {
        st_idle = 1'b0,
        st_arb  = 1'b1
    } state_t;

    state_t                                 state_q;
    state_t                                 state_d;
    logic [arb_pkg::row_w-1:0]              row_q;
    logic [row_idx_w-1:0]                   row_idx;
    logic [ROW_NUM-1:0][arb_pkg::mac_num-1:0] pend_q;
    logic [arb_pkg::mac_num-1:0]            cur_pend;
    logic                                   row_done;
    arb_pkg::psum_map_t                     map_q;

    // Border rows start with part of each channel already done
    function automatic logic [arb_pkg::mac_num-1:0] pad_word(input int r);
        logic [arb_pkg::chan_wei-1:0] chan;
        chan = '1;
        if (r == 0)                chan = 9'b111_000_000;
        else if (r == 1)           chan = 9'b111_111_000;
        else if (r == ROW_NUM - 2) chan = 9'b000_111_111;
        else if (r == ROW_NUM - 1) chan = 9'b000_000_111;
        return {arb_pkg::chan_num{chan}};
    endfunction

    // ==================================================================
    // Block FSM
    // ==================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (sta) state_d = st_arb;
            st_arb:  if (row_q == last_row && mac_switch == '0) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state_q <= st_idle;
        else        state_q <= state_d;
    end

    assign row_idx  = row_q[row_idx_w-1:0];
    assign cur_pend = pend_q[row_idx];
    assign row_done = (cur_pend == '0);

    // ==================================================================
    // Row, pending table and map
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q <= '0;
        end else if (state_d == st_idle) begin
            row_q <= '0;
        end else if (row_done && row_q < row_cnt && row_q < last_row) begin
            row_q <= row_q + 1'b1;                 // Next activation row is ready
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROW_NUM; r++) pend_q[r] <= pad_word(r);
        end else if (state_d == st_idle) begin
            for (int r = 0; r < ROW_NUM; r++) pend_q[r] <= pad_word(r);
        end else if (grant.valid) begin
            pend_q[row_idx][grant.wei_id] <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_q <= arb_pkg::base_psum_map;
        end else if (state_d == st_idle) begin
            map_q <= arb_pkg::base_psum_map;
        end else if (row_done && !row_on) begin
            // One slot upward per finished row
            for (int g = 0; g < arb_pkg::chan_num; g++) begin
                for (int s = 0; s < 3; s++) begin
                    for (int k = 0; k < 3; k++) begin
                        map_q[g*9 + s*3 + k] <= map_q[g*9 + ((s + 2) % 3)*3 + k];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) row_on <= 1'b0;
        else        row_on <= row_done;
    end

    assign info.arb_active = (state_q == st_arb);
    assign info.row        = row_q;
    assign info.pending    = cur_pend;
    assign info.map        = map_q;
    assign blk_fnh         = (state_q == st_idle);
    assign row_arb         = row_q;

    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        row_q <= last_row)
        else $error("Row index beyond last row");

endmodule

`default_nettype wire

//--- design/arb_top.sv
// Block arbiter top level

`default_nettype none

module arb_top #(
    parameter int ROW_NUM = 16
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     sta,
    input  wire logic [arb_pkg::row_w-1:0]                row_cnt,
    input  wire logic [arb_pkg::mac_num-1:0]              mac_req_help,
    input  wire logic [arb_pkg::psum_num-1:0]             psum_empty,
    output logic                                          blk_fnh,
    output logic [arb_pkg::mac_num-1:0]                   mac_rst,
    output arb_pkg::mac_assign_t [arb_pkg::mac_num-1:0]   mac_assign,
    output logic [arb_pkg::mac_num-1:0]                   mac_switch,
    output logic                                          row_on,
    output logic [arb_pkg::row_w-1:0]                     row_arb,
    output logic [arb_pkg::psum_num-1:0]                  psum_fnh
);

    arb_pkg::row_info_t info;
    arb_pkg::grant_t    grant;

    // ==================================================================
    // Row tracking, grant, then dispatch and psum
    // ==================================================================
    arb_row_tracker #(.ROW_NUM(ROW_NUM)) u_row_tracker (
        .clk(clk), .rst_n(rst_n), .sta(sta), .row_cnt(row_cnt),
        .grant(grant), .mac_switch(mac_switch),
        .info(info), .blk_fnh(blk_fnh), .row_on(row_on), .row_arb(row_arb)
    );

    arb_grant_select u_grant_select (
        .info(info), .mac_req_help(mac_req_help),
        .psum_empty(psum_empty), .psum_fnh(psum_fnh),
        .grant(grant)
    );

    arb_psum_tracker u_psum_tracker (
        .clk(clk), .rst_n(rst_n), .sta(sta), .grant(grant),
        .psum_empty(psum_empty), .psum_fnh(psum_fnh)
    );

    arb_mac_dispatch u_mac_dispatch (
        .clk(clk), .rst_n(rst_n), .sta(sta), .grant(grant),
        .mac_req_help(mac_req_help),
        .mac_rst(mac_rst), .mac_assign(mac_assign), .mac_switch(mac_switch)
    );

endmodule

`default_nettype wire

//--- dv/tb_arb_top.sv
// Block arbiter testbench
// MAC and activation model with a reference model of grants and psums

`default_nettype none

module tb_arb_top;

    localparam int ROW_NUM  = 16;
    localparam int MACS     = arb_pkg::mac_num;
    localparam int PSUMS    = arb_pkg::psum_num;
    localparam int BLOCKS   = 3;
    localparam int PERIOD   = 20;
    localparam int WATCHDOG = BLOCKS * ROW_NUM * MACS * 10;   // In cycles

    logic                                 clk;
    logic                                 rst_n;
    logic                                 sta;
    logic [7:0]                           row_cnt;
    logic [MACS-1:0]                      mac_req_help;
    logic [PSUMS-1:0]                     psum_empty;
    logic                                 blk_fnh;
    logic [MACS-1:0]                      mac_rst;
    arb_pkg::mac_assign_t [MACS-1:0]      mac_assign;
    logic [MACS-1:0]                      mac_switch;
    logic                                 row_on;
    logic [7:0]                           row_arb;
    logic [PSUMS-1:0]                     psum_fnh;

    int              errors = 0;
    int              grants = 0;
    int              blocks_done = 0;
    int              busy [MACS];
    logic [MACS-1:0] done_tab [ROW_NUM];     // Weights granted per row
    int              exp_cnt [PSUMS];
    logic [PSUMS-1:0] exp_fnh;
    logic            exp_valid;
    int              exp_wei;
    logic [MACS-1:0] prev_req;
    logic [MACS-1:0] prev_switch;
    logic [PSUMS-1:0] prev_empty;
    int              prev_row;
    logic            prev_blk;
    logic            prev_sta;
    logic            prev_done;

    arb_top #(.ROW_NUM(ROW_NUM)) UUT (
        .clk(clk), .rst_n(rst_n), .sta(sta), .row_cnt(row_cnt),
        .mac_req_help(mac_req_help), .psum_empty(psum_empty),
        .blk_fnh(blk_fnh), .mac_rst(mac_rst), .mac_assign(mac_assign),
        .mac_switch(mac_switch), .row_on(row_on), .row_arb(row_arb), .psum_fnh(psum_fnh)
    );

    task automatic log_fail(input string msg);
        errors++;
        $display("Fail at time %0t: %s", $time, msg);
    endtask

    task automatic clear_row_table();
        for (int r = 0; r < ROW_NUM; r++) done_tab[r] = '0;
    endtask

    // Weights already done in the padded border rows, same in every channel
    function automatic logic [MACS-1:0] padded_weights(input int r);
        logic [8:0] chan;
        chan = '0;
        if (r == 0)                chan = 9'b000_111_111;
        else if (r == 1)           chan = 9'b000_000_111;
        else if (r == ROW_NUM - 2) chan = 9'b111_000_000;
        else if (r == ROW_NUM - 1) chan = 9'b111_111_000;
        return {3{chan}};
    endfunction

    // Base map with slots moved up once per row
    function automatic int mapped_psum(input int w, input int r);
        int g;
        int src;
        int psum;
        g   = w / 9;
        src = ((w % 9) / 3 + 2 * (r % 3)) % 3;   // Base slot that lands here
        if (src == 0)      psum = 3 * g;
        else if (src == 1) psum = 3 * g + 2;
        else               psum = 3 * g + 1;
        return psum;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // MAC, psum and activation model
    // ======================================================================
    initial begin
        mac_req_help = '1;
        psum_empty   = '1;
        row_cnt      = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int m = 0; m < MACS; m++) begin
                if (mac_rst[m]) begin
                    busy[m] = 2 + int'($urandom % 7);   // 2 to 8 cycles of work
                    mac_req_help[m] = 1'b0;
                end else if (busy[m] > 0) begin
                    busy[m]--;
                    if (busy[m] == 0) mac_req_help[m] = 1'b1;
                end
            end
            psum_empty = psum_empty ^ PSUMS'($urandom & $urandom);
            if (blk_fnh) row_cnt = '0;
            else if (int'(row_cnt) < ROW_NUM && $urandom % 5 == 0) row_cnt = row_cnt + 8'd1;
        end
    end

    // ======================================================================
    // Checks, sampled mid-cycle
    // ======================================================================
    always @(negedge clk) begin
        int m_id;
        int wei;
        int gp;
        int row_now;
        int cnt_next;
        int pm;
        logic found;
        logic [MACS-1:0] pend;
        logic [MACS-1:0] sw_exp;
        pend = '0;
        if (!rst_n) begin
            assert (blk_fnh && mac_switch == '0 && mac_rst == '0 && psum_fnh == '1 &&
                    row_arb == '0)
                else log_fail("Outputs not at reset values");
            exp_fnh   = '1;
            exp_valid = 1'b0;
            for (int p = 0; p < PSUMS; p++) exp_cnt[p] = 0;
            clear_row_table();
            prev_done = 1'b0;
        end else begin
            row_now = int'(row_arb);
            gp = -1;
            assert ($onehot0(mac_rst)) else log_fail("mac_rst is not one-hot");
            assert ((mac_rst != '0) == exp_valid) else log_fail("Grant presence differs");
            if (mac_rst != '0) begin
                grants++;
                m_id = 0;
                for (int m = 0; m < MACS; m++) if (mac_rst[m]) m_id = m;
                assert (mac_rst == (prev_req & (~prev_req + MACS'(1))))
                    else log_fail("Granted MAC is not the lowest requester");
                wei = int'(mac_assign[m_id].wei);
                gp  = mapped_psum(wei, prev_row);
                assert (int'(mac_assign[m_id].row) == prev_row) else log_fail("Wrong row");
                assert (wei == exp_wei) else log_fail("Wrong weight granted");
                assert (int'(mac_assign[m_id].psum) == gp) else log_fail("Psum off the map");
                assert (!done_tab[prev_row][wei]) else log_fail("Weight granted twice");
                done_tab[prev_row][wei] = 1'b1;
            end

            // Psum fill model
            if (prev_sta) begin
                exp_fnh = '1;
                for (int p = 0; p < PSUMS; p++) exp_cnt[p] = 0;
            end else begin
                for (int p = 0; p < PSUMS; p++) begin
                    if (exp_fnh[p] && !prev_empty[p]) cnt_next = 0;
                    else if (gp == p) cnt_next = (exp_cnt[p] == arb_pkg::psum_fill - 1) ?
                                                 0 : exp_cnt[p] + 1;
                    else cnt_next = exp_cnt[p];
                    if (gp == p && prev_empty[p]) exp_fnh[p] = 1'b0;
                    else if (gp == p && exp_cnt[p] == arb_pkg::psum_fill - 1) exp_fnh[p] = 1'b1;
                    exp_cnt[p] = cnt_next;
                end
            end
            assert (psum_fnh == exp_fnh) else log_fail("psum_fnh differs from fill model");

            sw_exp = prev_sta ? '0 : ((prev_switch & ~prev_req) | mac_rst);
            assert (mac_switch == sw_exp) else log_fail("mac_switch not set or released");

            // Row progress
            assert (row_now <= int'(row_cnt)) else log_fail("row_arb ahead of row_cnt");
            if (blk_fnh) begin
                assert (row_now == 0) else log_fail("Row not zero in idle");
            end else if (row_now != prev_row) begin
                assert (row_now == prev_row + 1) else log_fail("Row skipped");
                assert ($countones(done_tab[prev_row]) ==
                        MACS - $countones(padded_weights(prev_row)))
                    else log_fail("Row advanced with weights missing");
            end
            assert (row_on == prev_done) else log_fail("row_on does not follow completion");

            // Block start and end
            if (blk_fnh && !prev_blk)
                assert (prev_row == ROW_NUM - 1 && prev_switch == '0)
                    else log_fail("Block ended early");
            if (!blk_fnh && prev_blk)
                assert (prev_sta) else log_fail("Block started without sta");
            if (prev_sta && prev_blk)
                assert (!blk_fnh && psum_fnh == '1 && mac_rst == '0)
                    else log_fail("Start did not open a clean block");
            if (sta && blk_fnh) begin
                assert (mac_switch == '0 && mac_rst == '0 && row_now == 0)
                    else log_fail("Idle state not clean before start");
                clear_row_table();
            end

            // Grant expected in this cycle
            if (!blk_fnh) pend = ~padded_weights(row_now) & ~done_tab[row_now];
            found   = 1'b0;
            exp_wei = 0;
            for (int w = MACS - 1; w >= 0; w--) begin
                pm = mapped_psum(w, row_now);
                if (pend[w] && (!exp_fnh[pm] || psum_empty[pm])) begin
                    found   = 1'b1;
                    exp_wei = w;
                end
            end
            exp_valid = !blk_fnh && found && mac_req_help != '0;
            prev_done = !blk_fnh && pend == '0;
        end
        prev_req    = mac_req_help;
        prev_switch = mac_switch;
        prev_empty  = psum_empty;
        prev_row    = int'(row_arb);
        prev_blk    = blk_fnh;
        prev_sta    = sta;
    end

    initial begin
        #(WATCHDOG * PERIOD);
        $display("Watchdog expired after %0d cycles, a block never finished", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(69188));
        rst_n = 1'b0;
        sta   = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int b = 0; b < BLOCKS; b++) begin
            repeat (12) @(posedge clk);        // Let MACs drain their switches
            #1 sta = 1'b1;
            @(posedge clk);
            #1 sta = 1'b0;
            @(posedge blk_fnh);
            blocks_done++;
        end
        repeat (4) @(posedge clk);
        $display("Blocks %0d, grants %0d, errors %0d", blocks_done, grants, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the block arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_arb_top \
    -f vlog.f --Mdir obj_dir -o sim_arb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_arb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0

//--- vlog.f
design/arb_pkg.sv
design/arb_row_tracker.sv
design/arb_grant_select.sv
design/arb_psum_tracker.sv
design/arb_mac_dispatch.sv
design/arb_top.sv
dv/tb_arb_top.sv
